// File: common/zx_mem_config.svh
`ifndef ZX_MEM_CONFIG_SVH
`define ZX_MEM_CONFIG_SVH

// ==============================
// CPU bus widths
// ==============================

// Z80 address and data
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// ==============================
// RAM side
// ==============================

// Byte address into the external RAM
`define ZX_RAM_AW 25

// Offset bits inside one 16K page
`define ZX_PAGE_BITS 14

// Upper region bits that sit above the ROM page number
`define ZX_ROM_REGION 3'b101

`endif

// File: common/zx_mem_pkg.sv
package zx_mem_pkg;

`include "zx_mem_config.svh"

	// Machine family, latched during reset
	typedef enum logic [1:0] {
		mach_128   = 2'd0,
		mach_48    = 2'd1,
		mach_plus3 = 2'd2
	} machine_t;

	typedef logic [2:0] bank_t;
	typedef logic [3:0] rom_page_t;
	typedef logic [2:0] border_t;
	typedef logic [`ZX_RAM_AW-1:0] ram_addr_t;

	// Port 7FFD layout
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;
		logic       rom_lo;
		logic       scr;
		bank_t      bank;
	} page_reg_t;

	// Port 1FFD layout, cfg[1] doubles as the ROM high bit
	typedef struct packed {
		logic [3:0] spare;
		logic       motor;
		logic [1:0] cfg;
		logic       special;
	} plus3_reg_t;

	typedef enum logic [1:0] {
		port_none = 2'd0,
		port_7ffd = 2'd1,
		port_1ffd = 2'd2,
		port_ula  = 2'd3
	} port_sel_t;

endpackage

// File: design/zx_io_ports.sv
`include "zx_mem_config.svh"

module zx_io_ports import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	input  logic                  iorq_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	input  machine_t              mach,
	input  logic                  locked,
	output logic                  io_strobe,
	output port_sel_t             io_port,
	output logic [`ZX_DATA_W-1:0] io_data,
	output logic                  ula_hit,
	output border_t               border,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic      io_wr;
	logic      io_wr_q;
	logic      io_rise;
	logic      hit_7ffd;
	logic      hit_1ffd;
	logic      hit_ula;
	port_sel_t port_sel;

	// I/O write outside of interrupt acknowledge
	assign io_wr   = ~iorq_n & ~wr_n & m1_n;
	assign io_rise = io_wr & ~io_wr_q;

	// ==============================
	// Port decode
	// ==============================

	// locked is also high on 48K
	assign hit_7ffd = ~addr[15] & ~addr[1] & (addr[14] | (mach != mach_plus3)) & ~locked;
	assign hit_1ffd = (addr[15:13] == 3'b000) & addr[12] & ~addr[1]
		& (mach == mach_plus3) & ~locked;
	assign hit_ula  = ~addr[0];

	// A paging port wins the port field while the ULA keeps its own flag
	always_comb begin
		if (hit_7ffd) begin
			port_sel = port_7ffd;
		end else if (hit_1ffd) begin
			port_sel = port_1ffd;
		end else if (hit_ula) begin
			port_sel = port_ula;
		end else begin
			port_sel = port_none;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q   <= 1'b0;
			io_strobe <= 1'b0;
			ula_hit   <= 1'b0;
		end else begin
			io_wr_q   <= io_wr;
			io_strobe <= io_rise & (port_sel != port_none);
			ula_hit   <= io_rise & hit_ula;
		end
	end

	// Port and data that travel with the strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_port <= port_none;
			io_data <= '0;
		end else begin
			io_port <= port_sel;
			io_data <= cpu_dout;
		end
	end

	// ==============================
	// ULA output latch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= '0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (ula_hit) begin
			border  <= border_t'(io_data[2:0]);
			ear_out <= io_data[4];
			mic_out <= io_data[3];
		end
	end

	// One strobe per bus write, however long the CPU holds it
	a_strobe_single: assert property (@(posedge clk_sys) disable iff (reset)
		io_strobe |=> !io_strobe);

endmodule

// File: paging/zx_paging_regs.sv
`include "zx_mem_config.svh"

module zx_paging_regs import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_t              machine,
	input  logic                  io_strobe,
	input  port_sel_t             io_port,
	input  logic [`ZX_DATA_W-1:0] io_data,
	output machine_t              mach,
	output logic                  locked,
	output page_reg_t             page_reg,
	output plus3_reg_t            plus3_reg
);

	// ==============================
	// Machine latch and registers
	// ==============================

	// Machine type follows the input only while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mach <= machine;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg  <= '0;
			plus3_reg <= '0;
		end else if (io_strobe) begin
			case (io_port)
				port_7ffd: begin
					page_reg <= page_reg_t'(io_data);
				end
				port_1ffd: begin
					plus3_reg <= plus3_reg_t'(io_data);
				end
				default: begin
					// ULA only, nothing to page
				end
			endcase
		end
	end

	// 48K has no paging at all, same as a locked 128K
	assign locked = page_reg.lock | (mach == mach_48);

	// ==============================
	// Checks
	// ==============================

	// Decoder must drop paging writes once the lock is set
	a_lock_holds: assert property (@(posedge clk_sys) disable iff (reset)
		(io_strobe && locked) |=> ($stable(page_reg) && $stable(plus3_reg)));

	// 1FFD only exists on +2A/+3
	a_plus3_only: assert property (@(posedge clk_sys) disable iff (reset)
		(mach != mach_plus3) |-> (plus3_reg == '0));

endmodule

// File: paging/zx_addr_map.sv
`include "zx_mem_config.svh"

module zx_addr_map import zx_mem_pkg::*; (
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  machine_t              mach,
	input  page_reg_t             page_reg,
	input  plus3_reg_t            plus3_reg,
	output ram_addr_t             ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic                  page_scr
);

	localparam int ROM_PAD = `ZX_RAM_AW - 3 - $bits(rom_page_t) - `ZX_PAGE_BITS;
	localparam int RAM_PAD = `ZX_RAM_AW - $bits(bank_t) - `ZX_PAGE_BITS;

	logic [1:0]              slot;
	logic [`ZX_PAGE_BITS-1:0] offset;
	logic                    special;
	logic                    rom_sel;
	rom_page_t               rom_page;
	bank_t                   bank;

	assign slot    = addr[15:14];
	assign offset  = addr[`ZX_PAGE_BITS-1:0];
	assign special = (mach == mach_plus3) & plus3_reg.special;
	assign rom_sel = ~special & (slot == 2'd0);

	// ==============================
	// ROM page select
	// ==============================
	always_comb begin
		if (mach == mach_plus3) begin
			rom_page = {2'b10, plus3_reg.cfg[1], page_reg.rom_lo};
		end else begin
			rom_page = {3'b011, (mach == mach_48) | page_reg.rom_lo};
		end
	end

	// ==============================
	// RAM bank per slot
	// ==============================
	always_comb begin
		if (special) begin
			// All-RAM configs 0123, 4567, 4563, 4763
			case (plus3_reg.cfg)
				2'd0:    bank = {1'b0, slot};
				2'd1:    bank = {1'b1, slot};
				2'd2:    bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: bank = (slot == 2'd3) ? 3'd3 : (slot == 2'd1) ? 3'd7 : {1'b1, slot};
			endcase
		end else begin
			case (slot)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				2'd3:    bank = page_reg.bank;
				default: bank = 3'd0;
			endcase
		end
	end

	always_comb begin
		if (rom_sel) begin
			ram_addr = {{ROM_PAD{1'b0}}, `ZX_ROM_REGION, rom_page, offset};
		end else begin
			ram_addr = {{RAM_PAD{1'b0}}, bank, offset};
		end
	end

	// ROM is read only outside special mode
	assign ram_rd   = ~mreq_n & ~rd_n;
	assign ram_we   = ~mreq_n & ~wr_n & ~rom_sel;
	assign page_scr = page_reg.scr;

	// Bus write into the bottom 16K with ROM paged in never reaches RAM
	always_comb begin
		a_rom_no_we: assert (!(ram_we && addr[15:14] == 2'd0 && !plus3_reg.special))
			else $error("RAM write enable raised for ROM slot");
	end

endmodule

// File: design/zx_mem_top.sv
`include "zx_mem_config.svh"

module zx_mem_top import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_t              machine,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	input  logic                  mreq_n,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	output ram_addr_t             ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we,
	output logic                  page_scr,
	output border_t               border,
	output logic                  ear_out,
	output logic                  mic_out
);

	logic                  io_strobe;
	port_sel_t             io_port;
	logic [`ZX_DATA_W-1:0] io_data;
	machine_t              mach;
	logic                  locked;
	page_reg_t             page_reg;
	plus3_reg_t            plus3_reg;

	// ULA hit is consumed inside the decoder
	zx_io_ports i_io_ports (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr),
		.cpu_dout  (cpu_dout),
		.iorq_n    (iorq_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.mach      (mach),
		.locked    (locked),
		.io_strobe (io_strobe),
		.io_port   (io_port),
		.io_data   (io_data),
		.ula_hit   (),
		.border    (border),
		.ear_out   (ear_out),
		.mic_out   (mic_out)
	);

	zx_paging_regs i_paging_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.machine   (machine),
		.io_strobe (io_strobe),
		.io_port   (io_port),
		.io_data   (io_data),
		.mach      (mach),
		.locked    (locked),
		.page_reg  (page_reg),
		.plus3_reg (plus3_reg)
	);

	zx_addr_map i_addr_map (
		.addr      (addr),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.mach      (mach),
		.page_reg  (page_reg),
		.plus3_reg (plus3_reg),
		.ram_addr  (ram_addr),
		.ram_rd    (ram_rd),
		.ram_we    (ram_we),
		.page_scr  (page_scr)
	);

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk_sys,
	output logic reset,
	input  logic reset_req
);

	timeunit 1ns;
	timeprecision 100ps;

	logic clk_q = 1'b0;
	logic rst_q = 1'b1;
	int   hold  = 4;

	// 4 ns period
	always #2 clk_q = ~clk_q;

	// Reset spans 4 rising edges, at power up and after each request
	always @(posedge clk_q) begin
		if (reset_req) begin
			rst_q <= 1'b1;
			hold  <= 4;
		end else if (hold > 1) begin
			hold <= hold - 1;
		end else begin
			rst_q <= 1'b0;
			hold  <= 0;
		end
	end

	assign clk_sys = clk_q;
	assign reset   = rst_q;

endmodule

// File: sim/zx_mem_tb.sv
`include "zx_mem_config.svh"

module zx_mem_tb import zx_mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// All tests together take about 4500 cycles
	localparam int MAX_CYCLES = 20000;

	logic                  clk_sys;
	logic                  reset;
	logic                  reset_req;
	machine_t              machine;
	logic [`ZX_ADDR_W-1:0] addr;
	logic [`ZX_DATA_W-1:0] cpu_dout;
	logic                  mreq_n;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  m1_n;
	ram_addr_t             ram_addr;
	logic                  ram_rd;
	logic                  ram_we;
	logic                  page_scr;
	border_t               border;
	logic                  ear_out;
	logic                  mic_out;

	// Reference copy of the machine, both paging ports and the ULA latch {ear, mic, border}
	machine_t              m_mach;
	logic [7:0]            m_page;
	logic [7:0]            m_plus3;
	logic [4:0]            m_ula;

	integer                seed = 32'h483b_8326;
	int                    cycles = 0;
	logic [31:0]           r;
	logic [3:0]            cfg_seen = '0;
	logic [3:0]            rom_seen = '0;

	tb_clock_gen i_clk_gen (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.reset_req (reset_req)
	);

	zx_mem_top i_dut (.*);

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// +3 all-RAM banks, one octal digit per slot, slot 0 first
	function automatic bank_t special_bank(input logic [1:0] cfg, input logic [1:0] slot);
		logic [11:0] banks;
		case (cfg)
			2'd0:    banks = 12'o0123;
			2'd1:    banks = 12'o4567;
			2'd2:    banks = 12'o4563;
			default: banks = 12'o4763;
		endcase
		special_bank = banks[9 - 3 * slot +: 3];
	endfunction

	function automatic ram_addr_t expected_ram_addr(input logic [15:0] a);
		logic      special;
		rom_page_t page;
		bank_t     bank;
		special = (m_mach == mach_plus3) && m_plus3[0];
		case (m_mach)
			mach_plus3: page = {2'b10, m_plus3[2], m_page[4]};
			mach_48:    page = 4'b0111;
			default:    page = {3'b011, m_page[4]};
		endcase
		if (special) begin
			bank = special_bank(m_plus3[2:1], a[15:14]);
		end else if (a[15:14] == 2'd3) begin
			bank = m_page[2:0];
		end else begin
			bank = (a[15:14] == 2'd2) ? 3'd2 : 3'd5;
		end
		if (!special && a[15:14] == 2'd0) begin
			expected_ram_addr = ram_addr_t'({`ZX_ROM_REGION, page, a[13:0]});
		end else begin
			expected_ram_addr = ram_addr_t'({bank, a[13:0]});
		end
	endfunction

	function automatic logic expected_ram_we(input logic [15:0] a, input logic wr_l);
		logic rom_paged;
		rom_paged = (a[15:14] == 2'd0) && !((m_mach == mach_plus3) && m_plus3[0]);
		expected_ram_we = !wr_l && !rom_paged;
	endfunction

	// Lock state is taken from before this write
	function automatic void model_io_write(input logic [15:0] a, input logic [7:0] d);
		logic no_paging;
		no_paging = m_page[5] || (m_mach == mach_48);
		if (!no_paging && !a[15] && !a[1] && (a[14] || m_mach != mach_plus3)) begin
			m_page = d;
		end
		if (!no_paging && m_mach == mach_plus3 && a[15:12] == 4'b0001 && !a[1]) begin
			m_plus3 = d;
		end
		if (!a[0]) begin
			m_ula = d[4:0];
		end
	endfunction

	function automatic void clear_model(input machine_t m);
		m_mach  = m;
		m_page  = 8'h00;
		m_plus3 = 8'h00;
		m_ula   = 5'd0;
	endfunction

	// ==============================
	// Checks
	// ==============================

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_addr(input ram_addr_t got, input ram_addr_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_border(input border_t got, input border_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("Error at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// Outputs settle after the posedge drive, so look at the falling edge
	always @(negedge clk_sys) begin
		if (!reset && !mreq_n) begin
			check_addr(ram_addr, expected_ram_addr(addr), "ram_addr");
			check_flag(ram_we, expected_ram_we(addr, wr_n), "ram_we");
			check_flag(ram_rd, !rd_n, "ram_rd");
			check_flag(page_scr, m_page[3], "page_scr");
			check_border(border, m_ula[2:0], "border");
			check_flag(mic_out, m_ula[3], "mic_out");
			check_flag(ear_out, m_ula[4], "ear_out");
			if (m_mach == mach_plus3 && m_plus3[0]) begin
				cfg_seen[m_plus3[2:1]] = 1'b1;
			end else if (m_mach == mach_plus3 && addr[15:14] == 2'd0) begin
				rom_seen[{m_plus3[2], m_page[4]}] = 1'b1;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			abort_run($sformatf("Timeout: the tests did not finish within %0d cycles", cycles));
		end
	end

	// ==============================
	// Bus cycles
	// ==============================

	task automatic wait_reset_done();
		do begin
			@(posedge clk_sys);
		end while (reset !== 1'b0);
	endtask

	task automatic restart(input machine_t m);
		@(posedge clk_sys);
		machine   <= m;
		reset_req <= 1'b1;
		@(posedge clk_sys);
		reset_req <= 1'b0;
		wait_reset_done();
		clear_model(m);
	endtask

	// Bus held for 3 cycles, then 2 idle
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		addr     <= a;
		cpu_dout <= d;
		iorq_n   <= 1'b0;
		wr_n     <= 1'b0;
		repeat (3) @(posedge clk_sys);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		@(posedge clk_sys);
		model_io_write(a, d);
	endtask

	task automatic mem_access(input logic [15:0] a, input logic write);
		@(posedge clk_sys);
		addr   <= a;
		mreq_n <= 1'b0;
		rd_n   <= write;
		wr_n   <= !write;
		@(posedge clk_sys);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic random_access();
		logic [31:0] pick;
		pick = next_rand();
		mem_access(pick[15:0], pick[16]);
	endtask

	task automatic run_ula_writes(input machine_t m);
		restart(m);
		repeat (60) begin
			r = next_rand();
			io_write({r[15:1], 1'b0}, r[23:16]);
			random_access();
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		reset_req = 1'b0;
		machine   = mach_128;
		addr      = '0;
		cpu_dout  = '0;
		mreq_n    = 1'b1;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		m1_n      = 1'b1;
		clear_model(mach_128);
		wait_reset_done();

		// Reset map on 128K, slot 3 and slot 0
		mem_access(16'hC123, 1'b0);
		mem_access(16'h0456, 1'b0);

		// 128K paging, lock forced by write 150 at the latest
		restart(mach_128);
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			io_write({1'b0, r[14:2], 1'b0, r[0]},
				{r[23:22], (r[31:27] == 5'd0) || (i == 150), r[20:16]});
			random_access();
		end

		// 48K ignores 7FFD and keeps ROM read only
		restart(mach_48);
		for (int i = 0; i < 50; i++) begin
			r = next_rand();
			io_write({1'b0, r[14:2], 2'b01}, r[23:16]);
			mem_access({2'b00, r[29:16]}, 1'b1);
		end

		// +3 with 1FFD and unlocked 7FFD writes
		restart(mach_plus3);
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			if (r[31]) begin
				io_write({4'b0001, r[11:2], 1'b0, r[0]}, r[23:16]);
			end else begin
				io_write({2'b01, r[13:2], 1'b0, r[0]}, r[23:16] & 8'hDF);
			end
			random_access();
		end
		if (cfg_seen != 4'hF) begin
			abort_run("Not every +3 special configuration was reached");
		end
		if (rom_seen != 4'hF) begin
			abort_run("Not every +3 ROM page was reached");
		end
		// Bit 14 low is no 7FFD on +3
		io_write(16'h3FFD, m_page ^ 8'h1F);
		mem_access(16'hC000, 1'b0);
		mem_access(16'h0000, 1'b1);

		run_ula_writes(mach_128);
		run_ula_writes(mach_48);
		run_ula_writes(mach_plus3);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: build.f
+incdir+common
common/zx_mem_pkg.sv
design/zx_io_ports.sv
paging/zx_paging_regs.sv
paging/zx_addr_map.sv
design/zx_mem_top.sv
sim/tb_clock_gen.sv
sim/zx_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f build.f \
	--top-module zx_mem_tb \
	-o zx_mem_sim

# The simulator exits non-zero on $fatal, so keep going and let the log decide
./obj_dir/zx_mem_sim 2>&1 | tee sim.log || true

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation passed"
